// File: common/matching_pkg.sv
// Sizes, payload structs and issue states shared by every block of the matching stage
`default_nettype none

package matching_pkg;

	// Loop buffer sizing
	localparam int LOOP_DEPTH = 16;
	localparam int LOOP_LIMIT = 8;

	// Byte distance between the two instructions of a fetched pair
	localparam int PC_STEP = 4;

	// Width of the registered and committed counters
	localparam int TRACK_WIDTH = 8;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [4:0] cmd_t;
	typedef logic [3:0] cc_t;

	// One-hot select of the execution unit
	typedef logic [9:0] ex_unit_t;

	// Occupancy needs one bit more than the pointer to hold a full buffer
	typedef logic [$clog2(LOOP_DEPTH):0] buf_count_t;

	typedef logic [2:0] commit_offset_t;
	typedef logic [1:0] issue_count_t;
	typedef logic [TRACK_WIDTH-1:0] track_count_t;

	// Decoded payload, carried through the stage untouched
	typedef struct packed {
		cmd_t cmd;
		cc_t cc;
		reg_idx_t source0;
		word_t source1;
		logic source1_imm;
		reg_idx_t destination;
		logic writeback;
		logic flags_writeback;
		ex_unit_t ex_unit;
	} op_t;

	typedef struct packed {
		logic valid;
		logic commit_wait;
		op_t op;
	} slot_t;

	// One loop buffer entry, pc belongs to slot 0
	typedef struct packed {
		slot_t slot0;
		slot_t slot1;
		word_t pc;
	} pair_t;

	// Lane pc is the pc of the instruction on lane 0
	typedef struct packed {
		logic lane0_valid;
		op_t lane0_op;
		logic lane1_valid;
		op_t lane1_op;
		word_t pc;
	} issue_t;

	typedef enum logic [1:0] {
		ISSUE_PAIR,
		ISSUE_WAIT_SLOT0,
		ISSUE_WAIT_SLOT1
	} issue_state_e;

endpackage

`default_nettype wire

// File: loop_buffer/loop_buffer.sv
// Show-ahead FIFO of fetched instruction pairs feeding the issue logic of the matching stage
`default_nettype none
`timescale 1ns/10ps

module loop_buffer (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire wr_valid,
	input wire matching_pkg::pair_t wr_pair,
	input wire pop,
	output matching_pkg::pair_t head,
	output logic empty,
	output logic full,
	output logic fetch_limit
);

	// Pair storage
	matching_pkg::pair_t mem [matching_pkg::LOOP_DEPTH];

	logic [$clog2(matching_pkg::LOOP_DEPTH)-1:0] wr_ptr;
	logic [$clog2(matching_pkg::LOOP_DEPTH)-1:0] rd_ptr;
	matching_pkg::buf_count_t count;

	logic do_write;
	logic do_read;

	// A pair offered while full is dropped here and held by fetch
	assign do_write = wr_valid && !full;
	assign do_read = pop && !empty;

	always_ff @(posedge iCLOCK) begin
		if (do_write) begin
			mem[wr_ptr] <= wr_pair;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else if (flush) begin
			// Restart drops every queued pair
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_write, do_read})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	// Show-ahead read straight from storage
	assign head = mem[rd_ptr];

	assign empty = (count == '0);
	assign full = (count == matching_pkg::buf_count_t'(matching_pkg::LOOP_DEPTH));

	// Asks fetch to slow down well before the buffer fills
	assign fetch_limit = (count >= matching_pkg::buf_count_t'(matching_pkg::LOOP_LIMIT));

	// Issue control must only pop a real head entry
	pop_not_empty: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(pop && empty)
	) else $error("loop buffer popped while empty");

endmodule

`default_nettype wire

// File: source/issue_control.sv
// Issue FSM of the matching stage; picks lanes from the buffer head and serializes commit-wait ops
`default_nettype none
`timescale 1ns/10ps

module issue_control (
	input wire iCLOCK,
	input wire inRESET,
	input wire free_default,
	input wire matching_pkg::pair_t head,
	input wire empty,
	input wire next_lock,
	input wire drained,
	output logic pop,
	output matching_pkg::issue_count_t issue_count,
	output matching_pkg::issue_t next
);

	matching_pkg::issue_state_e state;
	matching_pkg::issue_state_e state_next;

	logic blocked;
	logic slot1_plain;
	logic slot1_wait;
	logic lane0_valid;
	logic lane1_valid;

	// Nothing moves without a head entry or while the next stage is locked
	assign blocked = empty || next_lock;

	// An invalid slot 1 is neither plain nor waiting
	assign slot1_plain = head.slot1.valid && !head.slot1.commit_wait;
	assign slot1_wait = head.slot1.valid && head.slot1.commit_wait;

	always_comb begin
		lane0_valid = 1'b0;
		lane1_valid = 1'b0;
		pop = 1'b0;
		state_next = state;
		case (state)
			matching_pkg::ISSUE_PAIR: begin
				if (!empty && head.slot0.commit_wait) begin
					// Slot 0 must wait for the pipeline to drain
					state_next = matching_pkg::ISSUE_WAIT_SLOT0;
				end
				else if (!blocked) begin
					lane0_valid = 1'b1;
					lane1_valid = slot1_plain;
					// Keep the head when slot 1 still has to go alone
					pop = !slot1_wait;
					if (slot1_wait) begin
						state_next = matching_pkg::ISSUE_WAIT_SLOT1;
					end
				end
			end
			matching_pkg::ISSUE_WAIT_SLOT0: begin
				if (!blocked && drained) begin
					lane0_valid = 1'b1;
					lane1_valid = slot1_plain;
					pop = !slot1_wait;
					if (slot1_wait) begin
						state_next = matching_pkg::ISSUE_WAIT_SLOT1;
					end
					else begin
						state_next = matching_pkg::ISSUE_PAIR;
					end
				end
			end
			matching_pkg::ISSUE_WAIT_SLOT1: begin
				// Slot 1 goes alone on lane 0 after slot 0 has left
				if (!blocked && drained) begin
					lane0_valid = 1'b1;
					pop = 1'b1;
					state_next = matching_pkg::ISSUE_PAIR;
				end
			end
			default: begin
				state_next = matching_pkg::ISSUE_PAIR;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= matching_pkg::ISSUE_PAIR;
		end
		else if (free_default) begin
			state <= matching_pkg::ISSUE_PAIR;
		end
		else begin
			state <= state_next;
		end
	end

	// Lane 0 payload comes from slot 1 only in the slot 1 wait state
	always_comb begin
		next.lane0_valid = lane0_valid;
		next.lane1_valid = lane1_valid;
		next.lane1_op = head.slot1.op;
		if (state == matching_pkg::ISSUE_WAIT_SLOT1) begin
			next.lane0_op = head.slot1.op;
			next.pc = head.pc + matching_pkg::word_t'(matching_pkg::PC_STEP);
		end
		else begin
			next.lane0_op = head.slot0.op;
			next.pc = head.pc;
		end
	end

	// Count of instructions handed over this cycle
	assign issue_count = matching_pkg::issue_count_t'(lane0_valid) +
		matching_pkg::issue_count_t'(lane1_valid);

	// The slot 1 wait state stays on the head entry that caused it
	slot1_wait_holds_head: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!empty && state == matching_pkg::ISSUE_WAIT_SLOT1 |->
			head.slot1.valid && head.slot1.commit_wait
	) else $error("slot 1 wait state without a commit-wait slot 1 at the head");

endmodule

`default_nettype wire

// File: source/commit_tracker.sv
// Counts issued and committed instructions so the issue FSM knows when the pipeline is drained
`default_nettype none
`timescale 1ns/10ps

module commit_tracker (
	input wire iCLOCK,
	input wire inRESET,
	input wire restart,
	input wire matching_pkg::issue_count_t issue_count,
	input wire matching_pkg::commit_offset_t commit_offset,
	output logic drained
);

	matching_pkg::track_count_t regist_count;
	matching_pkg::track_count_t commit_count;
	matching_pkg::track_count_t outstanding;

	// Both counters wrap, only their difference matters
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			regist_count <= '0;
			commit_count <= '0;
		end
		else if (restart) begin
			regist_count <= '0;
			commit_count <= '0;
		end
		else begin
			regist_count <= regist_count + matching_pkg::track_count_t'(issue_count);
			commit_count <= commit_count + matching_pkg::track_count_t'(commit_offset);
		end
	end

	// Instructions issued but not yet committed
	assign outstanding = regist_count - commit_count;

	assign drained = (outstanding == '0);

	// Commits never overtake issues, so the gap stays in the lower half
	commit_behind_issue: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!outstanding[matching_pkg::TRACK_WIDTH-1]
	) else $error("committed count ran ahead of issued count");

endmodule

`default_nettype wire

// File: source/matching.sv
// Matching stage top; queues fetched pairs and issues them in order on two lanes
`default_nettype none
`timescale 1ns/10ps

module matching (
	input wire iCLOCK,
	input wire inRESET,
	input wire free_default,
	input wire free_restart,
	input wire matching_pkg::commit_offset_t commit_offset,
	input wire matching_pkg::pair_t previous,
	input wire next_lock,
	output wire previous_lock,
	output wire fetch_limit,
	output wire matching_pkg::issue_t next
);

	// Loop buffer to issue control
	matching_pkg::pair_t head;
	logic empty;
	logic full;

	// Issue control to buffer and tracker
	logic pop;
	matching_pkg::issue_count_t issue_count;

	// Tracker back to issue control
	logic drained;

	// Fetch is held while every entry is taken
	assign previous_lock = full;

	// Slot 0 is always valid in a real pair
	loop_buffer i_loop_buffer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(free_restart),
		.wr_valid(previous.slot0.valid),
		.wr_pair(previous),
		.pop(pop),
		.head(head),
		.empty(empty),
		.full(full),
		.fetch_limit(fetch_limit)
	);

	issue_control i_issue_control (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.free_default(free_default),
		.head(head),
		.empty(empty),
		.next_lock(next_lock),
		.drained(drained),
		.pop(pop),
		.issue_count(issue_count),
		.next(next)
	);

	// Restart also clears the in-flight count
	commit_tracker i_commit_tracker (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.restart(free_restart),
		.issue_count(issue_count),
		.commit_offset(commit_offset),
		.drained(drained)
	);

endmodule

`default_nettype wire

// File: test/tb_matching.sv
// Self-checking testbench for the matching stage, used as simulation top with the file list
`default_nettype none
`timescale 1ns/10ps

module tb_matching;

	localparam int TIMEOUT_CYCLES = 3000;

	// One expected instruction in program order
	typedef struct packed {
		matching_pkg::op_t op;
		matching_pkg::word_t pc;
		logic cw;
		logic last;
		logic slot1;
	} exp_t;

	logic iCLOCK;
	logic inRESET;
	logic free_default;
	logic free_restart;
	matching_pkg::commit_offset_t commit_offset;
	matching_pkg::pair_t previous;
	logic next_lock;
	logic previous_lock;
	logic fetch_limit;
	matching_pkg::issue_t next;

	exp_t exp_q[$];
	exp_t exp0;
	exp_t exp1;
	int exp_count;
	int issued;
	int committed;
	int pairs;
	int errors;
	int tests_run;
	int tests_bad;
	int cycle_count;
	logic commits_on;
	logic [15:0] lfsr_state;
	matching_pkg::word_t pc_next;

	matching i_matching (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.free_default(free_default),
		.free_restart(free_restart),
		.commit_offset(commit_offset),
		.previous(previous),
		.next_lock(next_lock),
		.previous_lock(previous_lock),
		.fetch_limit(fetch_limit),
		.next(next)
	);

	always #50 iCLOCK = ~iCLOCK;

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic matching_pkg::op_t random_op();
		matching_pkg::op_t op;
		op.cmd = matching_pkg::cmd_t'(rand_bits(5));
		op.cc = matching_pkg::cc_t'(rand_bits(4));
		op.source0 = matching_pkg::reg_idx_t'(rand_bits(5));
		op.source1 = rand_bits(32);
		op.source1_imm = 1'(rand_bits(1));
		op.destination = matching_pkg::reg_idx_t'(rand_bits(5));
		op.writeback = 1'(rand_bits(1));
		op.flags_writeback = 1'(rand_bits(1));
		op.ex_unit = matching_pkg::ex_unit_t'(10'b1 << (rand_bits(4) % 10));
		return op;
	endfunction

	// Scoreboard follows what the next stage takes and what fetch gets accepted
	always @(posedge iCLOCK) begin : model_update
		int n;
		int old_pairs;
		exp_t e;
		if (!inRESET || free_restart) begin
			exp_q.delete();
			issued = 0;
			committed = 0;
			pairs = 0;
		end
		else begin
			old_pairs = pairs;
			n = int'(next.lane0_valid) + int'(next.lane1_valid);
			repeat (n) begin
				if (exp_q.size() != 0) begin
					if (exp_q[0].last) begin
						pairs = pairs - 1;
					end
					void'(exp_q.pop_front());
				end
			end
			issued = issued + n;
			committed = committed + int'(commit_offset);
			// Full buffer drops the offered pair
			if (previous.slot0.valid && old_pairs < matching_pkg::LOOP_DEPTH) begin
				e = {previous.slot0.op, previous.pc, previous.slot0.commit_wait,
					!previous.slot1.valid, 1'b0};
				exp_q.push_back(e);
				if (previous.slot1.valid) begin
					e = {previous.slot1.op, previous.pc + 32'd4,
						previous.slot1.commit_wait, 1'b1, 1'b1};
					exp_q.push_back(e);
				end
				pairs = pairs + 1;
			end
		end
		exp_count = exp_q.size();
		exp0 = (exp_count > 0) ? exp_q[0] : '0;
		exp1 = (exp_count > 1) ? exp_q[1] : '0;
	end

	lane0_has_entry: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane0_valid |-> exp_count > 0)
	else begin
		errors = errors + 1;
		$display("At %0t ns lane 0 issued an instruction that was never accepted", $time);
	end

	lane0_op_check: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane0_valid && exp_count > 0 |-> next.lane0_op == exp0.op)
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: next.lane0_op got %h expected %h", $time,
			$sampled(next.lane0_op), $sampled(exp0.op));
	end

	lane0_pc_check: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane0_valid && exp_count > 0 |-> next.pc == exp0.pc)
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: next.pc got %h expected %h", $time,
			$sampled(next.pc), $sampled(exp0.pc));
	end

	// Lane 1 only carries the plain slot 1 of the pair on lane 0
	lane1_pairing: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane1_valid |-> exp_count > 1 && !exp0.slot1 && exp1.slot1 && !exp1.cw)
	else begin
		errors = errors + 1;
		$display("At %0t ns lane 1 carried an instruction out of its pair", $time);
	end

	lane1_op_check: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane1_valid && exp_count > 1 |-> next.lane1_op == exp1.op)
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: next.lane1_op got %h expected %h", $time,
			$sampled(next.lane1_op), $sampled(exp1.op));
	end

	lane1_used: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane0_valid && exp_count > 1 && !exp0.slot1 && exp1.slot1 && !exp1.cw
		|-> next.lane1_valid)
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: next.lane1_valid got 0 expected 1", $time);
	end

	wait_until_drained: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next.lane0_valid && exp_count > 0 && exp0.cw |-> issued == committed)
	else begin
		errors = errors + 1;
		$display("At %0t ns a commit-wait instruction issued before earlier commits", $time);
	end

	lock_blocks_lanes: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock |-> {next.lane0_valid, next.lane1_valid} == 2'b00)
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: next lane valids got %b expected 00", $time,
			$sampled({next.lane0_valid, next.lane1_valid}));
	end

	fetch_limit_check: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		fetch_limit == (pairs >= matching_pkg::LOOP_LIMIT))
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: fetch_limit got %b expected %b", $time,
			$sampled(fetch_limit), $sampled(pairs >= matching_pkg::LOOP_LIMIT));
	end

	previous_lock_check: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		previous_lock == (pairs == matching_pkg::LOOP_DEPTH))
	else begin
		errors = errors + 1;
		$display("FAILED at %0t ns: previous_lock got %b expected %b", $time,
			$sampled(previous_lock), $sampled(pairs == matching_pkg::LOOP_DEPTH));
	end

	always @(posedge iCLOCK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	// Every stimulus cycle starts here, commits never exceed what is outstanding
	task automatic step_clock();
		int outstanding;
		logic [31:0] r;
		@(negedge iCLOCK);
		outstanding = issued - committed;
		r = '0;
		if (commits_on) begin
			r = rand_bits(3);
			if (int'(r) > outstanding) begin
				r = outstanding;
			end
		end
		commit_offset = matching_pkg::commit_offset_t'(r);
	endtask

	task automatic offer_pair(input logic s1_valid, input logic cw0, input logic cw1);
		step_clock();
		previous.slot0 = {1'b1, cw0, random_op()};
		previous.slot1 = {s1_valid, cw1, random_op()};
		previous.pc = pc_next;
		pc_next = pc_next + 32'd8;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			step_clock();
			previous.slot0.valid = 1'b0;
			previous.slot1.valid = 1'b0;
		end
	endtask

	task automatic drain_all(input logic random_lock);
		commits_on = 1'b1;
		idle_cycles(1);
		while (exp_q.size() != 0 || issued != committed) begin
			step_clock();
			next_lock = random_lock ? 1'(rand_bits(1)) : 1'b0;
		end
		next_lock = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run = tests_run + 1;
		if (errors == errors_before) begin
			$display("Test %s finished without errors", name);
		end
		else begin
			tests_bad = tests_bad + 1;
			$display("Test %s finished with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic order_test();
		int errors_before;
		errors_before = errors;
		commits_on = 1'b1;
		repeat (40) begin
			offer_pair(rand_bits(2) != 0, 1'b0, 1'b0);
		end
		drain_all(1'b0);
		report_test("order and content", errors_before);
	endtask

	// Commits stay off for a while so the commit-wait op has to wait
	task automatic slot0_wait_test();
		int errors_before;
		errors_before = errors;
		for (int i = 0; i < 4; i++) begin
			commits_on = 1'b0;
			offer_pair(1'b1, 1'b0, 1'b0);
			offer_pair(1'(rand_bits(1)), 1'b1, 1'b0);
			offer_pair(1'b1, 1'b0, 1'b0);
			idle_cycles(4);
			drain_all(1'b0);
		end
		report_test("slot 0 commit-wait", errors_before);
	endtask

	task automatic slot1_wait_test();
		int errors_before;
		errors_before = errors;
		for (int i = 0; i < 4; i++) begin
			commits_on = 1'b0;
			offer_pair(1'b1, 1'b0, 1'b0);
			offer_pair(1'b1, i == 3, 1'b1);
			offer_pair(1'b1, 1'b0, 1'b0);
			idle_cycles(4);
			drain_all(1'b0);
		end
		report_test("slot 1 commit-wait", errors_before);
	endtask

	// Next stage locked while fetch overfills the buffer
	task automatic backpressure_test();
		int errors_before;
		errors_before = errors;
		commits_on = 1'b1;
		repeat (20) begin
			offer_pair(1'(rand_bits(1)), 1'b0, 1'b0);
			next_lock = 1'b1;
		end
		drain_all(1'b1);
		report_test("back-pressure", errors_before);
	endtask

	task automatic restart_test();
		int errors_before;
		int waited;
		errors_before = errors;
		commits_on = 1'b0;
		offer_pair(1'b1, 1'b0, 1'b0);
		offer_pair(1'b1, 1'b0, 1'b0);
		offer_pair(1'b0, 1'b1, 1'b0);
		offer_pair(1'b1, 1'b0, 1'b0);
		idle_cycles(3);
		free_restart = 1'b1;
		free_default = 1'b1;
		idle_cycles(1);
		free_restart = 1'b0;
		free_default = 1'b0;
		idle_cycles(3);
		offer_pair(1'b1, 1'b1, 1'b0);
		idle_cycles(1);
		waited = 0;
		while (exp_q.size() != 0 && waited < 6) begin
			idle_cycles(1);
			waited = waited + 1;
		end
		if (exp_q.size() != 0) begin
			errors = errors + 1;
			$display("Commit-wait instruction after restart did not issue within 6 cycles");
		end
		drain_all(1'b0);
		report_test("restart and default", errors_before);
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		free_default = 1'b0;
		free_restart = 1'b0;
		commit_offset = '0;
		previous = '0;
		next_lock = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_bad = 0;
		cycle_count = 0;
		commits_on = 1'b0;
		lfsr_state = 16'd49112;
		pc_next = 32'h0000_1000;
		repeat (5) @(negedge iCLOCK);
		inRESET = 1'b1;
		order_test();
		slot0_wait_test();
		slot1_wait_test();
		backpressure_test();
		restart_test();
		idle_cycles(2);
		$display("Tests run: %0d, tests with errors: %0d, check failures: %0d",
			tests_run, tests_bad, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end
		else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
common/matching_pkg.sv
loop_buffer/loop_buffer.sv
source/issue_control.sv
source/commit_tracker.sv
source/matching.sv
test/tb_matching.sv
